// ==== common/wb_cache_pkg.sv ====
// Shared widths and bus records of the two-way write-back cache
// that bridges a Wishbone slave port to an FML burst port

package wb_cache_pkg;

	// Address split: tag | set | word
	localparam int DAT_W     = 32;
	localparam int SEL_W     = 4;
	localparam int WORD_W    = 2;
	localparam int SET_W     = 7;
	localparam int TAG_W     = 15;
	localparam int ADR_W     = TAG_W + SET_W + WORD_W;
	localparam int FML_ADR_W = TAG_W + SET_W;

	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
		logic [SEL_W-1:0] sel;
		logic             we;
	} wb_req_t;

	// One stored word and its byte valid mask
	typedef struct packed {
		logic [DAT_W-1:0] dat;
		logic [SEL_W-1:0] valid;
	} way_line_t;

	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic             dirty;
	} tag_entry_t;

	typedef struct packed {
		logic             hit;
		logic             sel_valid;
		logic             dirty;
		logic [TAG_W-1:0] tag;
	} way_stat_t;

	// Fill and spill are one-cycle pulses
	typedef struct packed {
		logic             fill;
		logic             spill;
		logic             way;
		logic [TAG_W-1:0] tag;
		logic [SET_W-1:0] set;
	} mover_cmd_t;

endpackage

// ==== cache/cache_way.sv ====
// One cache way: tag and dirty store, data and byte-valid store,
// hit detection and Wishbone byte merge. Port A serves the Wishbone
// side, port B serves the line mover

`timescale 1ns/1ps

module cache_way import wb_cache_pkg::*; (
	input  logic              clk,
	input  wb_req_t           req_i,
	input  logic              a_we_i,
	input  logic              a_tag_we_i,
	output way_stat_t         stat_o,
	output way_line_t         line_o,
	input  logic [SET_W-1:0]  b_set_i,
	input  logic [WORD_W-1:0] b_word_i,
	input  logic              b_we_i,
	input  logic [DAT_W-1:0]  b_dat_i,
	input  logic              b_tag_we_i,
	input  logic [TAG_W-1:0]  b_tag_i,
	output way_line_t         b_line_o
);

	localparam int LINES = 2 ** SET_W;
	localparam int WORDS = 2 ** (SET_W + WORD_W);

	tag_entry_t        tag_ram  [LINES];
	way_line_t         data_ram [WORDS];
	tag_entry_t        tag_q;
	way_line_t         merged;
	logic [SET_W-1:0]  a_set;
	logic [WORD_W-1:0] a_word;
	logic [TAG_W-1:0]  a_tag;

	assign a_word = req_i.adr[WORD_W-1:0];
	assign a_set  = req_i.adr[WORD_W +: SET_W];
	assign a_tag  = req_i.adr[WORD_W + SET_W +: TAG_W];

	// Empty cache at power-up
	initial begin
		for (int i = 0; i < LINES; i++) begin
			tag_ram[i] = '0;
		end
		for (int i = 0; i < WORDS; i++) begin
			data_ram[i] = '0;
		end
	end

	// ------------------------------
	// Tag and dirty store
	// ------------------------------
	always_ff @(posedge clk) begin
		if (a_tag_we_i)
			tag_ram[a_set] <= '{tag: a_tag, dirty: 1'b1};
		// Mover loads a filled tag or clears dirty after a spill
		if (b_tag_we_i)
			tag_ram[b_set_i] <= '{tag: b_tag_i, dirty: 1'b0};
		tag_q <= tag_ram[a_set];
	end

	// ------------------------------
	// Data and valid store
	// ------------------------------
	always_ff @(posedge clk) begin
		if (a_we_i)
			data_ram[{a_set, a_word}] <= merged;
		if (b_we_i)
			data_ram[{b_set_i, b_word_i}] <= '{dat: b_dat_i, valid: '1};
		line_o   <= data_ram[{a_set, a_word}];
		b_line_o <= data_ram[{b_set_i, b_word_i}];
	end

	// Selected bytes replace the stored ones and become valid
	always_comb begin
		merged = line_o;
		for (int i = 0; i < SEL_W; i++) begin
			if (req_i.sel[i]) begin
				merged.dat[8*i +: 8] = req_i.dat[8*i +: 8];
				merged.valid[i]      = 1'b1;
			end
		end
	end

	assign stat_o = '{
		hit:       (tag_q.tag == a_tag),
		sel_valid: ((~line_o.valid & req_i.sel) == '0),
		dirty:     tag_q.dirty,
		tag:       tag_q.tag
	};

	// Controller and mover never write the same line at once
	a_b_same_set: assert property (@(posedge clk)
		!(a_we_i && b_we_i && (a_set == b_set_i)));

endmodule

// ==== cache/cache_ctrl.sv ====
// Wishbone side of the cache. Decides hit, spill and fill, keeps
// the per-set LRU bit and drives the port A writes of both ways

`timescale 1ns/1ps

module cache_ctrl import wb_cache_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic [ADR_W-1:0] wbs_adr_i,
	input  logic [DAT_W-1:0] wbs_dat_i,
	input  logic [SEL_W-1:0] wbs_sel_i,
	input  logic             wbs_cyc_i,
	input  logic             wbs_stb_i,
	input  logic             wbs_we_i,
	output logic [DAT_W-1:0] wbs_dat_o,
	output logic             wbs_ack_o,
	output wb_req_t          req_o,
	input  way_stat_t [1:0]  stat_i,
	input  way_line_t [1:0]  line_i,
	output logic [1:0]       way_we_o,
	output logic [1:0]       tag_we_o,
	output mover_cmd_t       cmd_o,
	input  logic             ls_busy_i
);

	localparam int SETS = 2 ** SET_W;

	typedef enum logic [2:0] {
		S_IDLE, S_READ, S_RSPILL, S_RFILL, S_WRITE, S_WSPILL
	} state_t;

	state_t           state;
	logic             lru_ram [SETS];
	logic             lru_q;
	logic             lru_we;
	logic             acc_way;
	logic [SET_W-1:0] set;
	logic [TAG_W-1:0] tag;
	logic [1:0]       hit;
	logic [1:0]       rd_ok;
	logic             hit_way;
	logic             rd_way;
	logic             tgt_way;
	way_stat_t        tgt;
	logic             issue_fill;
	logic             issue_spill;
	logic             cmd_way;
	logic [TAG_W-1:0] cmd_tag;
	logic             cmd_fill_q;
	logic             cmd_spill_q;
	logic             cmd_way_q;
	logic [TAG_W-1:0] cmd_tag_q;
	logic [SET_W-1:0] cmd_set_q;

	assign req_o = '{adr: wbs_adr_i, dat: wbs_dat_i, sel: wbs_sel_i, we: wbs_we_i};
	assign set   = wbs_adr_i[WORD_W +: SET_W];
	assign tag   = wbs_adr_i[WORD_W + SET_W +: TAG_W];

	assign hit     = {stat_i[1].hit, stat_i[0].hit};
	assign rd_ok   = {stat_i[1].hit & stat_i[1].sel_valid, stat_i[0].hit & stat_i[0].sel_valid};
	assign hit_way = ~hit[0];
	assign rd_way  = ~rd_ok[0];
	// A partly valid hit line is refilled in place, otherwise the LRU way
	assign tgt_way = (|hit) ? hit_way : lru_q;
	assign tgt     = stat_i[tgt_way];

	// ------------------------------
	// LRU bit names the victim way
	// ------------------------------
	initial begin
		for (int i = 0; i < SETS; i++) begin
			lru_ram[i] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (lru_we)
			lru_ram[set] <= ~acc_way;
		lru_q <= lru_ram[set];
	end

	// ------------------------------
	// Hit handling and mover orders
	// ------------------------------
	always_comb begin
		wbs_ack_o   = 1'b0;
		way_we_o    = 2'b00;
		tag_we_o    = 2'b00;
		lru_we      = 1'b0;
		acc_way     = rd_way;
		issue_fill  = 1'b0;
		issue_spill = 1'b0;
		cmd_way     = tgt_way;
		cmd_tag     = tag;
		case (state)
			S_READ: begin
				if (|rd_ok) begin
					wbs_ack_o = 1'b1;
					lru_we    = 1'b1;
				end else if (!ls_busy_i) begin
					issue_spill = tgt.dirty;
					issue_fill  = ~tgt.dirty;
				end
			end
			S_RSPILL: begin
				// Victim written back, now bring in the requested line
				issue_fill = ~ls_busy_i;
				cmd_way    = cmd_way_q;
			end
			S_WRITE: begin
				acc_way = hit_way;
				if (|hit) begin
					wbs_ack_o         = 1'b1;
					lru_we            = 1'b1;
					way_we_o[hit_way] = 1'b1;
					tag_we_o[hit_way] = 1'b1;
				end else if (!ls_busy_i) begin
					// Write miss allocates through a fill so no stale bytes survive
					issue_spill = tgt.dirty;
					issue_fill  = ~tgt.dirty;
				end
			end
			default: begin
			end
		endcase
		if (issue_spill)
			cmd_tag = tgt.tag;
	end

	assign wbs_dat_o = line_i[rd_way].dat;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_IDLE;
			cmd_fill_q  <= 1'b0;
			cmd_spill_q <= 1'b0;
		end else begin
			cmd_fill_q  <= issue_fill;
			cmd_spill_q <= issue_spill;
			case (state)
				S_IDLE: begin
					if (wbs_cyc_i && wbs_stb_i)
						state <= wbs_we_i ? S_WRITE : S_READ;
				end
				S_READ: begin
					if (|rd_ok)
						state <= S_IDLE;
					else if (issue_spill)
						state <= S_RSPILL;
					else if (issue_fill)
						state <= S_RFILL;
				end
				S_RSPILL: begin
					if (!ls_busy_i)
						state <= S_RFILL;
				end
				S_RFILL: begin
					if (!ls_busy_i)
						state <= S_READ;
				end
				S_WRITE: begin
					if (|hit)
						state <= S_IDLE;
					else if (!ls_busy_i)
						state <= S_WSPILL;
				end
				S_WSPILL: begin
					// Retry the write once the mover has settled
					if (!ls_busy_i)
						state <= S_WRITE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_fill || issue_spill) begin
			cmd_way_q <= cmd_way;
			cmd_tag_q <= cmd_tag;
			cmd_set_q <= set;
		end
	end

	assign cmd_o = '{fill: cmd_fill_q, spill: cmd_spill_q, way: cmd_way_q,
		tag: cmd_tag_q, set: cmd_set_q};

	// Master holds its request until acked
	ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		wbs_ack_o |-> (wbs_cyc_i && wbs_stb_i));

	cmd_when_idle: assert property (@(posedge clk) disable iff (rst)
		(cmd_o.fill || cmd_o.spill) |-> !$past(ls_busy_i));

endmodule

// ==== cache/line_mover.sv ====
// Load/store engine. Spills a victim line as an FML write burst and
// fills a line from an FML read burst through port B of the ways

`timescale 1ns/1ps

module line_mover import wb_cache_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  mover_cmd_t        cmd_i,
	output logic              ls_busy_o,
	output logic [SET_W-1:0]  b_set_o,
	output logic [WORD_W-1:0] b_word_o,
	output logic [1:0]        b_we_o,
	output logic [1:0]        b_tag_we_o,
	output logic [TAG_W-1:0]  b_tag_o,
	output logic [DAT_W-1:0]  b_dat_o,
	input  way_line_t [1:0]   b_line_i,
	output logic              fml_rd_o,
	output logic              fml_wr_o,
	output logic [DAT_W-1:0]  fml_wdat_o,
	output logic [SEL_W-1:0]  fml_wbe_o,
	output logic              fml_wnext_o,
	input  logic              fml_done_i,
	input  logic              fml_rempty_i,
	input  logic [DAT_W-1:0]  fml_rdat_i,
	output logic              fml_rnext_o
);

	typedef enum logic [1:0] {L_IDLE, L_SPILL, L_WAITDONE, L_FILL} ls_state_t;

	ls_state_t         state;
	logic [WORD_W-1:0] cnt;
	logic              way_q;
	logic              wnext_q;
	logic              fill_full;
	logic              fill_wr;
	logic              tag_wr;

	assign ls_busy_o = (state != L_IDLE) || cmd_i.fill || cmd_i.spill;

	// Take a word whenever the read FIFO has one
	assign fill_wr = (state == L_FILL) && !fml_rempty_i && !fill_full;
	assign tag_wr  = (fill_wr && (cnt == '1)) ||
		((state == L_WAITDONE) && fml_wr_o && fml_done_i);

	assign b_word_o    = cnt;
	assign b_dat_o     = fml_rdat_i;
	assign b_we_o      = fill_wr ? (way_q ? 2'b10 : 2'b01) : 2'b00;
	assign b_tag_we_o  = tag_wr ? (way_q ? 2'b10 : 2'b01) : 2'b00;
	assign fml_rnext_o = fill_wr;

	// Port B read lags its address by one cycle
	assign fml_wnext_o = wnext_q;
	assign fml_wdat_o  = b_line_i[way_q].dat;
	assign fml_wbe_o   = b_line_i[way_q].valid;

	always_ff @(posedge clk) begin
		if ((state == L_IDLE) && (cmd_i.fill || cmd_i.spill)) begin
			way_q   <= cmd_i.way;
			b_tag_o <= cmd_i.tag;
			b_set_o <= cmd_i.set;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= L_IDLE;
			cnt       <= '0;
			wnext_q   <= 1'b0;
			fill_full <= 1'b0;
			fml_rd_o  <= 1'b0;
			fml_wr_o  <= 1'b0;
		end else begin
			wnext_q <= (state == L_SPILL);
			case (state)
				L_IDLE: begin
					cnt <= '0;
					if (cmd_i.spill) begin
						state <= L_SPILL;
					end else if (cmd_i.fill) begin
						state    <= L_FILL;
						fml_rd_o <= 1'b1;
					end
				end
				L_SPILL: begin
					cnt <= cnt + 1'b1;
					if (cnt == '1)
						state <= L_WAITDONE;
				end
				L_WAITDONE: begin
					// Last wnext goes out before wr rises
					if (!fml_wr_o) begin
						fml_wr_o <= 1'b1;
					end else if (fml_done_i) begin
						fml_wr_o <= 1'b0;
						state    <= L_IDLE;
					end
				end
				L_FILL: begin
					if (fill_wr) begin
						cnt <= cnt + 1'b1;
						if (cnt == '1)
							fill_full <= 1'b1;
					end
					if (fml_done_i)
						fml_rd_o <= 1'b0;
					// Leave only with all four words and the burst closed
					if (fill_full && !fml_rd_o) begin
						fill_full <= 1'b0;
						state     <= L_IDLE;
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(fml_rd_o && fml_wr_o));

endmodule

// ==== verilog/wb_cache.sv ====
// Two-way write-back cache between a Wishbone slave port and an FML
// burst port. Wires the controller, both ways and the line mover

`timescale 1ns/1ps

module wb_cache import wb_cache_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	// Wishbone slave
	input  logic [ADR_W-1:0]     wbs_adr_i,
	input  logic [DAT_W-1:0]     wbs_dat_i,
	input  logic [SEL_W-1:0]     wbs_sel_i,
	input  logic                 wbs_cyc_i,
	input  logic                 wbs_stb_i,
	input  logic                 wbs_we_i,
	output logic [DAT_W-1:0]     wbs_dat_o,
	output logic                 wbs_ack_o,
	// FML master
	output logic                 fml_rd_o,
	output logic                 fml_wr_o,
	output logic [FML_ADR_W-1:0] fml_adr_o,
	output logic [DAT_W-1:0]     fml_wdat_o,
	output logic [SEL_W-1:0]     fml_wbe_o,
	output logic                 fml_wnext_o,
	input  logic                 fml_done_i,
	input  logic                 fml_rempty_i,
	input  logic [DAT_W-1:0]     fml_rdat_i,
	output logic                 fml_rnext_o
);

	wb_req_t               req;
	way_stat_t [1:0]       stat;
	way_line_t [1:0]       line;
	way_line_t [1:0]       b_line;
	logic      [1:0]       way_we;
	logic      [1:0]       tag_we;
	mover_cmd_t            cmd;
	logic                  ls_busy;
	logic      [SET_W-1:0]  b_set;
	logic      [WORD_W-1:0] b_word;
	logic      [1:0]       b_we;
	logic      [1:0]       b_tag_we;
	logic      [TAG_W-1:0]  b_tag;
	logic      [DAT_W-1:0]  b_dat;

	cache_ctrl ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.wbs_adr_i  (wbs_adr_i),
		.wbs_dat_i  (wbs_dat_i),
		.wbs_sel_i  (wbs_sel_i),
		.wbs_cyc_i  (wbs_cyc_i),
		.wbs_stb_i  (wbs_stb_i),
		.wbs_we_i   (wbs_we_i),
		.wbs_dat_o  (wbs_dat_o),
		.wbs_ack_o  (wbs_ack_o),
		.req_o      (req),
		.stat_i     (stat),
		.line_i     (line),
		.way_we_o   (way_we),
		.tag_we_o   (tag_we),
		.cmd_o      (cmd),
		.ls_busy_i  (ls_busy)
	);

	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_way way_inst (
			.clk        (clk),
			.req_i      (req),
			.a_we_i     (way_we[w]),
			.a_tag_we_i (tag_we[w]),
			.stat_o     (stat[w]),
			.line_o     (line[w]),
			.b_set_i    (b_set),
			.b_word_i   (b_word),
			.b_we_i     (b_we[w]),
			.b_dat_i    (b_dat),
			.b_tag_we_i (b_tag_we[w]),
			.b_tag_i    (b_tag),
			.b_line_o   (b_line[w])
		);
	end

	line_mover mover_inst (
		.clk          (clk),
		.rst          (rst),
		.cmd_i        (cmd),
		.ls_busy_o    (ls_busy),
		.b_set_o      (b_set),
		.b_word_o     (b_word),
		.b_we_o       (b_we),
		.b_tag_we_o   (b_tag_we),
		.b_tag_o      (b_tag),
		.b_dat_o      (b_dat),
		.b_line_i     (b_line),
		.fml_rd_o     (fml_rd_o),
		.fml_wr_o     (fml_wr_o),
		.fml_wdat_o   (fml_wdat_o),
		.fml_wbe_o    (fml_wbe_o),
		.fml_wnext_o  (fml_wnext_o),
		.fml_done_i   (fml_done_i),
		.fml_rempty_i (fml_rempty_i),
		.fml_rdat_i   (fml_rdat_i),
		.fml_rnext_o  (fml_rnext_o)
	);

	// Line address of the burst in flight
	assign fml_adr_o = {b_tag, b_set};

endmodule

// ==== testbench/fml_mem_model.sv ====
// Behavioral FML memory with four-word bursts and byte-enabled writes
// Contents start as the word address XOR a fixed pattern

`timescale 1ns/1ps

module fml_mem_model import wb_cache_pkg::*; #(
	parameter logic [DAT_W-1:0] INIT_XOR = 32'h0
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rd_i,
	input  logic                 wr_i,
	input  logic [FML_ADR_W-1:0] adr_i,
	input  logic [DAT_W-1:0]     wdat_i,
	input  logic [SEL_W-1:0]     wbe_i,
	input  logic                 wnext_i,
	output logic                 done_o,
	output logic                 rempty_o,
	output logic [DAT_W-1:0]     rdat_o,
	input  logic                 rnext_i
);

	logic [DAT_W-1:0] mem [logic [ADR_W-1:0]];
	logic [DAT_W-1:0] wbuf [4];
	logic [SEL_W-1:0] bebuf [4];
	logic [1:0]       wcnt;
	logic [2:0]       rcnt;
	logic [1:0]       lat;
	logic             stall;

	function automatic logic [DAT_W-1:0] peek(input logic [ADR_W-1:0] a);
		if (mem.exists(a))
			return mem[a];
		return DAT_W'(a) ^ INIT_XOR;
	endfunction

	// A word every other cycle, four per burst
	assign rempty_o = !(rd_i && (rcnt < 3'd4) && !stall);

	always_comb begin
		rdat_o = peek({adr_i, rcnt[1:0]});
	end

	always @(posedge clk) begin
		logic [ADR_W-1:0] a;
		logic [DAT_W-1:0] w;
		if (rst) begin
			done_o <= 1'b0;
			wcnt   <= '0;
			rcnt   <= '0;
			lat    <= '0;
			stall  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			stall  <= ~stall;
			if (wnext_i) begin
				wbuf[wcnt]  <= wdat_i;
				bebuf[wcnt] <= wbe_i;
				wcnt        <= wcnt + 2'd1;
			end
			if (rnext_i)
				rcnt <= rcnt + 3'd1;
			// Done comes a few cycles into wr, or after the fourth read word
			if ((wr_i || (rd_i && rcnt == 3'd4)) && !done_o) begin
				if (lat == 2'd2) begin
					done_o <= 1'b1;
					lat    <= '0;
					rcnt   <= '0;
					if (wr_i) begin
						for (int k = 0; k < 4; k++) begin
							a = {adr_i, 2'(k)};
							w = peek(a);
							for (int b = 0; b < SEL_W; b++) begin
								if (bebuf[k][b])
									w[8*b +: 8] = wbuf[k][8*b +: 8];
							end
							mem[a] = w;
						end
					end
				end else begin
					lat <= lat + 2'd1;
				end
			end
		end
	end

endmodule

// ==== testbench/tb_wb_cache.sv ====
// Testbench for the Wishbone to FML write-back cache
// Directed eviction cases, then LFSR traffic over three tags and four sets

`timescale 1ns/1ps

module tb_wb_cache import wb_cache_pkg::*; ();

	localparam logic [DAT_W-1:0] INIT_XOR  = 32'hA5C3_1E69;
	localparam logic [TAG_W-1:0] TAG0      = 15'h0135;
	localparam logic [TAG_W-1:0] TAG1      = 15'h2A4C;
	localparam logic [TAG_W-1:0] TAG2      = 15'h7301;
	localparam logic [SET_W-1:0] SET_BASE  = 7'h2C;
	localparam int               N_RAND    = 150;
	localparam int               N_OPS     = N_RAND + 6;
	// Spill, fill and retry of one request stay well below this
	localparam int               OP_CYCLES = 80;
	localparam int               TIMEOUT_NS = (N_OPS * OP_CYCLES + 20) * 100;

	logic                 clk = 1'b0;
	logic                 rst;
	logic [ADR_W-1:0]     wbs_adr_i;
	logic [DAT_W-1:0]     wbs_dat_i;
	logic [SEL_W-1:0]     wbs_sel_i;
	logic                 wbs_cyc_i;
	logic                 wbs_stb_i;
	logic                 wbs_we_i;
	logic [DAT_W-1:0]     wbs_dat_o;
	logic                 wbs_ack_o;
	logic                 fml_rd_o;
	logic                 fml_wr_o;
	logic [FML_ADR_W-1:0] fml_adr_o;
	logic [DAT_W-1:0]     fml_wdat_o;
	logic [SEL_W-1:0]     fml_wbe_o;
	logic                 fml_wnext_o;
	logic                 fml_done_i;
	logic                 fml_rempty_i;
	logic [DAT_W-1:0]     fml_rdat_i;
	logic                 fml_rnext_o;

	logic [DAT_W-1:0]     ref_mem [logic [ADR_W-1:0]];
	logic [DAT_W-1:0]     exp_dat;
	logic                 started;
	logic [2:0]           wnext_cnt;
	logic [2:0]           rnext_cnt;
	logic [15:0]          lfsr = 16'd25034;
	int                   mismatch_cnt = 0;
	int                   proto_cnt = 0;

	always #50 clk = ~clk;

	wb_cache wb_cache_inst (
		.clk(clk), .rst(rst),
		.wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i), .wbs_sel_i(wbs_sel_i),
		.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
		.wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
		.fml_rd_o(fml_rd_o), .fml_wr_o(fml_wr_o), .fml_adr_o(fml_adr_o),
		.fml_wdat_o(fml_wdat_o), .fml_wbe_o(fml_wbe_o), .fml_wnext_o(fml_wnext_o),
		.fml_done_i(fml_done_i), .fml_rempty_i(fml_rempty_i),
		.fml_rdat_i(fml_rdat_i), .fml_rnext_o(fml_rnext_o)
	);

	fml_mem_model #(.INIT_XOR(INIT_XOR)) mem_inst (
		.clk(clk), .rst(rst), .rd_i(fml_rd_o), .wr_i(fml_wr_o), .adr_i(fml_adr_o),
		.wdat_i(fml_wdat_o), .wbe_i(fml_wbe_o), .wnext_i(fml_wnext_o),
		.done_o(fml_done_i), .rempty_o(fml_rempty_i), .rdat_o(fml_rdat_i),
		.rnext_i(fml_rnext_o)
	);

	// ------------------------------
	// Reference model and helpers
	// ------------------------------
	function automatic logic [DAT_W-1:0] byte_mask(input logic [SEL_W-1:0] sel);
		logic [DAT_W-1:0] m;
		m = '0;
		for (int i = 0; i < SEL_W; i++) begin
			if (sel[i])
				m[8*i +: 8] = 8'hFF;
		end
		return m;
	endfunction

	function automatic logic [DAT_W-1:0] ref_word(input logic [ADR_W-1:0] a);
		if (ref_mem.exists(a))
			return ref_mem[a];
		return DAT_W'(a) ^ INIT_XOR;
	endfunction

	function automatic logic [ADR_W-1:0] make_adr(input logic [1:0] t,
		input logic [1:0] s, input logic [1:0] w);
		logic [TAG_W-1:0] tag;
		case (t)
			2'd0:    tag = TAG0;
			2'd1:    tag = TAG1;
			default: tag = TAG2;
		endcase
		return {tag, SET_BASE + {5'b0, s}, w};
	endfunction

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic wb_access(input logic [ADR_W-1:0] adr, input logic we,
		input logic [SEL_W-1:0] sel, input logic [DAT_W-1:0] dat);
		logic [DAT_W-1:0] old;
		old = ref_word(adr);
		started   <= 1'b1;
		wbs_adr_i <= adr;
		wbs_dat_i <= dat;
		wbs_sel_i <= sel;
		wbs_we_i  <= we;
		wbs_cyc_i <= 1'b1;
		wbs_stb_i <= 1'b1;
		exp_dat   <= old;
		@(posedge clk);
		while (!wbs_ack_o)
			@(posedge clk);
		if (we)
			ref_mem[adr] = (old & ~byte_mask(sel)) | (dat & byte_mask(sel));
	endtask

	// Burst length counters, cleared by done
	always @(posedge clk) begin
		if (rst) begin
			wnext_cnt <= '0;
			rnext_cnt <= '0;
		end else begin
			if (fml_wr_o && fml_done_i)
				wnext_cnt <= '0;
			else if (fml_wnext_o)
				wnext_cnt <= wnext_cnt + 3'd1;
			if (fml_rd_o && fml_done_i)
				rnext_cnt <= '0;
			else if (fml_rnext_o)
				rnext_cnt <= rnext_cnt + 3'd1;
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------
	quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		!started |-> !(wbs_ack_o || fml_rd_o || fml_wr_o || fml_wnext_o || fml_rnext_o))
		else begin
			proto_cnt++;
			$display("At %0t an output went high before the first request", $time);
		end

	read_data: assert property (@(posedge clk) disable iff (rst)
		(wbs_ack_o && !wbs_we_i) |->
		((wbs_dat_o & byte_mask(wbs_sel_i)) == (exp_dat & byte_mask(wbs_sel_i))))
		else begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: read of %h sel %b returned %h, expected %h",
				$time, $sampled(wbs_adr_i), $sampled(wbs_sel_i),
				$sampled(wbs_dat_o), $sampled(exp_dat));
		end

	spill_data: assert property (@(posedge clk) disable iff (rst)
		fml_wnext_o |-> ((fml_wdat_o & byte_mask(fml_wbe_o)) ==
		(ref_word({fml_adr_o, wnext_cnt[1:0]}) & byte_mask(fml_wbe_o))))
		else begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: spill of line %h word %0d carried %h with enables %b",
				$time, $sampled(fml_adr_o), $sampled(wnext_cnt),
				$sampled(fml_wdat_o), $sampled(fml_wbe_o));
		end

	write_burst_len: assert property (@(posedge clk) disable iff (rst)
		(fml_wr_o && fml_done_i) |-> (wnext_cnt == 3'd4))
		else begin
			proto_cnt++;
			$display("At %0t a write burst ended after %0d wnext pulses instead of four",
				$time, $sampled(wnext_cnt));
		end

	read_burst_len: assert property (@(posedge clk) disable iff (rst)
		(fml_rd_o && fml_done_i) |-> (rnext_cnt == 3'd4))
		else begin
			proto_cnt++;
			$display("At %0t a read burst ended after %0d words instead of four",
				$time, $sampled(rnext_cnt));
		end

	rd_wr_apart: assert property (@(posedge clk) disable iff (rst)
		!(fml_rd_o && fml_wr_o))
		else begin
			proto_cnt++;
			$display("At %0t fml_rd_o and fml_wr_o were high together", $time);
		end

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		logic [31:0]      r;
		logic [1:0]       t;
		logic [ADR_W-1:0] a;
		logic [SEL_W-1:0] sel;
		logic [DAT_W-1:0] d;
		rst       = 1'b1;
		wbs_adr_i = '0;
		wbs_dat_i = '0;
		wbs_sel_i = '0;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i  = 1'b0;
		started   = 1'b0;
		exp_dat   = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk);

		// Three tags in one set, partial bytes, so a dirty line gets evicted
		wb_access(make_adr(2'd0, 2'd1, 2'd1), 1'b1, 4'b0101, 32'h1111_2222);
		wb_access(make_adr(2'd1, 2'd1, 2'd2), 1'b1, 4'b1000, 32'h3333_4444);
		wb_access(make_adr(2'd2, 2'd1, 2'd3), 1'b1, 4'b0011, 32'h5555_6666);
		wb_access(make_adr(2'd0, 2'd1, 2'd1), 1'b0, 4'b1111, '0);
		wb_access(make_adr(2'd1, 2'd1, 2'd2), 1'b0, 4'b1111, '0);
		wb_access(make_adr(2'd2, 2'd1, 2'd3), 1'b0, 4'b1111, '0);

		for (int i = 0; i < N_RAND; i++) begin
			rand_bits(2, r);
			t = (r[1:0] == 2'd3) ? 2'd0 : r[1:0];
			rand_bits(4, r);
			a = make_adr(t, r[3:2], r[1:0]);
			rand_bits(4, r);
			sel = (r[3:0] == 4'd0) ? 4'hF : r[3:0];
			rand_bits(32, r);
			d = r;
			rand_bits(1, r);
			wb_access(a, r[0], sel, d);
		end
		wbs_cyc_i <= 1'b0;
		wbs_stb_i <= 1'b0;
		repeat (4) @(posedge clk);

		$display("Errors: %0d value mismatches, %0d protocol failures",
			mismatch_cnt, proto_cnt);
		if (mismatch_cnt == 0 && proto_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== wb_cache.f ====
common/wb_cache_pkg.sv
cache/cache_way.sv
cache/cache_ctrl.sv
cache/line_mover.sv
verilog/wb_cache.sv
testbench/fml_mem_model.sv
testbench/tb_wb_cache.sv

// ==== Makefile ====
# Verilator build and run of the write-back cache testbench

SIM := obj_dir/Vtb_wb_cache
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM): wb_cache.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_cache \
		-f wb_cache.f -o Vtb_wb_cache

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@! grep -q "Simulation FAILED" $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
